// File: instruction_cache.f
+incdir+src
src/icache_pkg.sv
src/icache_refill_if.sv
src/icache_way_store.sv
src/icache_lru_table.sv
src/icache_refill_ctrl.sv
src/instruction_cache.sv
test/instruction_cache_tb.sv

// File: src/icache_lru_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_lru_table
    import icache_pkg::*;
(
    input  logic     CLK,
    input  logic     arst_n,
    input  logic     rd_en,
    input  set_idx_t rd_set,
    output way_t     lru_way,
    input  logic     upd_en,
    input  set_idx_t upd_set,
    input  way_t     used_way
);

    // One bit per set, naming the next victim
    logic [`ICACHE_SETS-1:0] lru_bits;

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            lru_bits <= '0;
            lru_way  <= 1'b0;
        end
        else
        begin
            if (upd_en)
            begin
                lru_bits[upd_set] <= ~used_way;
            end
            // Same-edge update to the read set wins
            if (rd_en)
            begin
                if (upd_en && (upd_set == rd_set))
                begin
                    lru_way <= ~used_way;
                end
                else
                begin
                    lru_way <= lru_bits[rd_set];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    typedef logic [`ICACHE_ADDR_W-1:0]       fetch_addr_t;
    typedef logic [`ICACHE_WORD_W-1:0]       instr_t;
    typedef logic [`ICACHE_TAG_W-1:0]        tag_t;
    typedef logic [`ICACHE_SET_SEL_W-1:0]    set_idx_t;
    typedef logic [`ICACHE_WORD_SEL_W-1:0]   word_sel_t;

    // Tag and set index, as sent to L2
    typedef logic [`ICACHE_BLOCK_ADDR_W-1:0] block_addr_t;

    // Word 0 in the low bits
    typedef logic [`ICACHE_BLOCK_W-1:0]      cache_block_t;

    typedef logic                            way_t;

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        WAIT_DATA,
        WRITE
    } refill_state_t;

endpackage

`default_nettype wire

// File: src/icache_refill_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module icache_refill_ctrl
    import icache_pkg::*;
(
    input  logic          CLK,
    input  logic          arst_n,
    icache_refill_if.ctrl refill,
    output logic          idle,
    output logic          l2_addr_valid,
    input  logic          l2_addr_ready,
    output block_addr_t   l2_addr,
    output logic          l2_data_ready,
    input  logic          l2_data_valid,
    input  cache_block_t  l2_data
);

    refill_state_t state;
    refill_state_t state_next;
    block_addr_t   block_addr_q;
    way_t          way_q;
    cache_block_t  block_q;

    ////////////////////
    // Refill FSM
    ////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (refill.miss)
                begin
                    state_next = REQUEST;
                end
            end
            REQUEST:
            begin
                if (l2_addr_ready)
                begin
                    state_next = WAIT_DATA;
                end
            end
            WAIT_DATA:
            begin
                if (l2_data_valid)
                begin
                    state_next = WRITE;
                end
            end
            WRITE:
            begin
                state_next = IDLE;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // Miss address, victim and returned block
    always_ff @(posedge CLK)
    begin
        if ((state == IDLE) && refill.miss)
        begin
            block_addr_q <= refill.miss_block_addr;
            way_q        <= refill.victim_way;
        end
        if ((state == WAIT_DATA) && l2_data_valid)
        begin
            block_q <= l2_data;
        end
    end

    ////////////////////
    // Outputs
    ////////////////////

    assign idle          = (state == IDLE);
    assign l2_addr_valid = (state == REQUEST);
    assign l2_addr       = block_addr_q;
    assign l2_data_ready = (state == WAIT_DATA);

    assign refill.refill_write = (state == WRITE);
    assign refill.refill_block = block_q;
    assign refill.refill_way   = way_q;

endmodule

`default_nettype wire

// File: src/icache_refill_if.sv
`timescale 1ns/10ps
`default_nettype none

interface icache_refill_if
    import icache_pkg::*;
();

    // Miss request from IF3
    logic         miss;
    block_addr_t  miss_block_addr;
    way_t         victim_way;

    // Block write back into the ways
    logic         refill_write;
    cache_block_t refill_block;
    way_t         refill_way;

    modport lookup (
        output miss,
        output miss_block_addr,
        output victim_way,
        input  refill_write,
        input  refill_block,
        input  refill_way
    );

    modport ctrl (
        input  miss,
        input  miss_block_addr,
        input  victim_way,
        output refill_write,
        output refill_block,
        output refill_way
    );

endinterface

`default_nettype wire

// File: src/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// Fetch address and instruction
`define ICACHE_ADDR_W      32
`define ICACHE_WORD_W      32

// Block geometry
`define ICACHE_WORDS       4
`define ICACHE_BLOCK_W     (`ICACHE_WORDS * `ICACHE_WORD_W)

// Organisation
`define ICACHE_SETS        16
`define ICACHE_WAYS        2

// Address fields, tag 24 | set 4 | word 2 | byte 2
`define ICACHE_BYTE_SEL_W  2
`define ICACHE_WORD_SEL_W  2
`define ICACHE_SET_SEL_W   4
`define ICACHE_TAG_W       24

`define ICACHE_BLOCK_ADDR_W (`ICACHE_TAG_W + `ICACHE_SET_SEL_W)

`endif

// File: src/icache_way_store.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module icache_way_store
    import icache_pkg::*;
(
    input  logic         CLK,
    input  logic         arst_n,
    input  logic         rd_en,
    input  set_idx_t     rd_set,
    input  tag_t         lookup_tag,
    output logic         hit,
    output tag_t         rd_tag,
    output cache_block_t rd_block,
    input  logic         wr_en,
    input  set_idx_t     wr_set,
    input  tag_t         wr_tag,
    input  cache_block_t wr_block
);

    tag_t                    tag_mem  [`ICACHE_SETS];
    cache_block_t            data_mem [`ICACHE_SETS];
    logic [`ICACHE_SETS-1:0] valid_bits;
    logic                    rd_valid;

    ////////////////////
    // Tag and data arrays
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (wr_en)
        begin
            tag_mem[wr_set]  <= wr_tag;
            data_mem[wr_set] <= wr_block;
        end
        if (rd_en)
        begin
            rd_tag   <= tag_mem[rd_set];
            rd_block <= data_mem[rd_set];
        end
    end

    ////////////////////
    // Valid bits
    ////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_bits <= '0;
            rd_valid   <= 1'b0;
        end
        else
        begin
            if (wr_en)
            begin
                valid_bits[wr_set] <= 1'b1;
            end
            if (rd_en)
            begin
                rd_valid <= valid_bits[rd_set];
            end
        end
    end

    // Compare against the IF2 tag
    assign hit = rd_valid && (rd_tag == lookup_tag);

endmodule

`default_nettype wire

// File: src/instruction_cache.sv
`timescale 1ns/10ps
`default_nettype none

`include "icache_settings.svh"

module instruction_cache
    import icache_pkg::*;
(
    input  logic         CLK,
    input  logic         arst_n,
    input  logic         stall,
    input  fetch_addr_t  pc,
    input  logic         pc_valid,
    output logic         cache_ready,
    output instr_t       instruction,
    output logic         instruction_valid,
    output logic         l2_addr_valid,
    input  logic         l2_addr_ready,
    output block_addr_t  l2_addr,
    output logic         l2_data_ready,
    input  logic         l2_data_valid,
    input  cache_block_t l2_data
);

    localparam int WORD_LSB = `ICACHE_BYTE_SEL_W;
    localparam int SET_LSB  = WORD_LSB + `ICACHE_WORD_SEL_W;
    localparam int TAG_LSB  = SET_LSB + `ICACHE_SET_SEL_W;

    icache_refill_if refill_bus ();

    fetch_addr_t             pc_if2;
    fetch_addr_t             pc_if3;
    logic                    valid_if2;
    logic                    valid_if3;
    logic [`ICACHE_WAYS-1:0] hit_if2;
    logic [`ICACHE_WAYS-1:0] hit_if3;
    cache_block_t            block_if2 [`ICACHE_WAYS];
    cache_block_t            block_if3 [`ICACHE_WAYS];
    way_t                    lru_if2;
    way_t                    lru_if3;
    way_t                    hit_way_if3;
    way_t                    used_way;
    set_idx_t                set_if1;
    set_idx_t                set_if2;
    set_idx_t                set_if3;
    set_idx_t                rd_set;
    tag_t                    tag_if2;
    tag_t                    tag_if3;
    word_sel_t               word_if3;
    logic [`ICACHE_WAYS-1:0] way_wr;
    cache_block_t            block_sel;
    instr_t                  word_out;
    logic                    accept;
    logic                    advance;
    logic                    replay;
    logic                    miss;
    logic                    idle;
    logic                    rd_en;
    logic                    lru_upd;
    logic                    complete_hit;
    logic                    complete_refill;

    assign set_if1  = pc[SET_LSB +: `ICACHE_SET_SEL_W];
    assign set_if2  = pc_if2[SET_LSB +: `ICACHE_SET_SEL_W];
    assign tag_if2  = pc_if2[TAG_LSB +: `ICACHE_TAG_W];
    assign set_if3  = pc_if3[SET_LSB +: `ICACHE_SET_SEL_W];
    assign tag_if3  = pc_if3[TAG_LSB +: `ICACHE_TAG_W];
    assign word_if3 = pc_if3[WORD_LSB +: `ICACHE_WORD_SEL_W];

    ////////////////////
    // Pipeline control
    ////////////////////

    assign miss        = valid_if3 && !(|hit_if3);
    assign cache_ready = !miss && idle && !replay;
    assign accept      = pc_valid && cache_ready && !stall;
    assign advance     = !stall && !miss && !replay;

    // IF2 fetch re-reads the arrays right after a refill
    assign rd_en  = accept || replay;
    assign rd_set = replay ? set_if2 : set_if1;

    assign hit_way_if3     = hit_if3[1];
    assign complete_hit    = valid_if3 && (|hit_if3) && advance;
    assign complete_refill = refill_bus.refill_write && !stall;

    assign lru_upd  = complete_hit || refill_bus.refill_write;
    assign used_way = refill_bus.refill_write ? refill_bus.refill_way : hit_way_if3;
    assign way_wr   = refill_bus.refill_write ? (2'b01 << refill_bus.refill_way) : 2'b00;

    assign refill_bus.miss            = miss;
    assign refill_bus.miss_block_addr = pc_if3[`ICACHE_ADDR_W-1:SET_LSB];
    assign refill_bus.victim_way      = lru_if3;

    ////////////////////
    // Storage
    ////////////////////

    for (genvar w = 0; w < `ICACHE_WAYS; w++)
    begin : g_way
        icache_way_store u_way_store (
            .CLK        (CLK),
            .arst_n     (arst_n),
            .rd_en      (rd_en),
            .rd_set     (rd_set),
            .lookup_tag (tag_if2),
            .hit        (hit_if2[w]),
            .rd_tag     (),
            .rd_block   (block_if2[w]),
            .wr_en      (way_wr[w]),
            .wr_set     (set_if3),
            .wr_tag     (tag_if3),
            .wr_block   (refill_bus.refill_block)
        );
    end

    icache_lru_table u_lru_table (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .rd_en    (rd_en),
        .rd_set   (rd_set),
        .lru_way  (lru_if2),
        .upd_en   (lru_upd),
        .upd_set  (set_if3),
        .used_way (used_way)
    );

    icache_refill_ctrl u_refill_ctrl (
        .CLK           (CLK),
        .arst_n        (arst_n),
        .refill        (refill_bus),
        .idle          (idle),
        .l2_addr_valid (l2_addr_valid),
        .l2_addr_ready (l2_addr_ready),
        .l2_addr       (l2_addr),
        .l2_data_ready (l2_data_ready),
        .l2_data_valid (l2_data_valid),
        .l2_data       (l2_data)
    );

    ////////////////////
    // IF2 and IF3 stages
    ////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            valid_if2 <= 1'b0;
            valid_if3 <= 1'b0;
            hit_if3   <= '0;
            lru_if3   <= 1'b0;
            replay    <= 1'b0;
        end
        else
        begin
            replay <= refill_bus.refill_write;
            if (refill_bus.refill_write)
            begin
                // A stalled miss stays in IF3 as a hit on the new block
                valid_if3 <= stall;
                hit_if3   <= 2'b01 << refill_bus.refill_way;
            end
            else if (advance)
            begin
                valid_if2 <= accept;
                valid_if3 <= valid_if2;
                hit_if3   <= hit_if2;
                lru_if3   <= (lru_upd && (set_if3 == set_if2)) ? ~used_way : lru_if2;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            pc_if2 <= pc;
        end
        if (refill_bus.refill_write)
        begin
            block_if3[refill_bus.refill_way] <= refill_bus.refill_block;
        end
        else if (advance)
        begin
            pc_if3    <= pc_if2;
            block_if3 <= block_if2;
        end
    end

    ////////////////////
    // Word select and output
    ////////////////////

    assign block_sel = refill_bus.refill_write ? refill_bus.refill_block
                                               : block_if3[hit_way_if3];
    assign word_out  = block_sel[word_if3 * `ICACHE_WORD_W +: `ICACHE_WORD_W];

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            instruction_valid <= 1'b0;
        end
        else
        begin
            instruction_valid <= complete_hit || complete_refill;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (complete_hit || complete_refill)
        begin
            instruction <= word_out;
        end
    end

endmodule

`default_nettype wire

// File: test/instruction_cache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module instruction_cache_tb
    import icache_pkg::*;
();

    localparam instr_t PATTERN = 32'h5a3c_96e1;
    localparam int     TIMEOUT = 200;

    logic         CLK;
    logic         arst_n;
    logic         stall;
    fetch_addr_t  pc;
    logic         pc_valid;
    logic         cache_ready;
    instr_t       instruction;
    logic         instruction_valid;
    logic         l2_addr_valid;
    logic         l2_addr_ready;
    block_addr_t  l2_addr;
    logic         l2_data_ready;
    logic         l2_data_valid;
    cache_block_t l2_data;

    // Reference cache state
    tag_t         model_tag   [16][2];
    logic         model_valid [16][2];
    way_t         model_lru   [16];
    int           model_misses;

    // Expected instructions in acceptance order, with the return cycle or -1
    instr_t       exp_q [$];
    int           due_q [$];

    integer       seed;
    int           cycle_count;
    int           err_count;
    int           test_count;
    int           test_errs;
    int           l2_count;
    int           addr_wait;
    int           data_wait;
    block_addr_t  pending_addr;
    logic         aborted;
    string        test_name;

    initial
    begin
        CLK = 1'b0;
    end

    always #10 CLK = ~CLK;

    instruction_cache u_instruction_cache (
        .CLK               (CLK),
        .arst_n            (arst_n),
        .stall             (stall),
        .pc                (pc),
        .pc_valid          (pc_valid),
        .cache_ready       (cache_ready),
        .instruction       (instruction),
        .instruction_valid (instruction_valid),
        .l2_addr_valid     (l2_addr_valid),
        .l2_addr_ready     (l2_addr_ready),
        .l2_addr           (l2_addr),
        .l2_data_ready     (l2_data_ready),
        .l2_data_valid     (l2_data_valid),
        .l2_data           (l2_data)
    );

    ////////////////////
    // Helpers
    ////////////////////

    // Memory contents as seen from L2
    function automatic instr_t pattern_word(input fetch_addr_t addr);
        return {addr[31:2], 2'b00} ^ PATTERN;
    endfunction

    function automatic cache_block_t l2_block(input block_addr_t baddr);
        cache_block_t blk;
        for (int i = 0; i < 4; i++)
        begin
            blk[i*32 +: 32] = pattern_word({baddr, 2'(i), 2'b00});
        end
        return blk;
    endfunction

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp_val,
                               input logic [31:0] got_val);
        assert (got_val === exp_val)
        else
        begin
            $display("[ERROR] %s: %s expected %h, actual %h", test_name, what, exp_val, got_val);
            err_count++;
        end
    endtask

    task automatic abort_run(input string msg);
        $display("%s: %s", test_name, msg);
        aborted = 1'b1;
        err_count++;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = err_count;
    endtask

    task automatic end_test();
        $display("%s finished with %0d errors", test_name, err_count - test_errs);
        test_count++;
    endtask

    // Two ways and one LRU bit per set
    task automatic model_access(input fetch_addr_t addr, output logic hit);
        set_idx_t s;
        tag_t     t;
        way_t     w;
        s   = addr[7:4];
        t   = addr[31:8];
        hit = 1'b0;
        w   = model_lru[s];
        for (int i = 0; i < 2; i++)
        begin
            if (model_valid[s][i] && (model_tag[s][i] == t))
            begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit)
        begin
            model_tag[s][w]   = t;
            model_valid[s][w] = 1'b1;
            model_misses++;
        end
        model_lru[s] = ~w;
    endtask

    // Accepted on the coming edge, so a hit returns three ticks later
    task automatic record_accept(input fetch_addr_t addr, input logic timed);
        logic hit;
        model_access(addr, hit);
        exp_q.push_back(pattern_word(addr));
        due_q.push_back((timed && hit) ? cycle_count + 3 : -1);
    endtask

    // L2 side, decided where the DUT outputs are stable
    task automatic respond_l2();
        l2_addr_ready = 1'b0;
        l2_data_valid = 1'b0;
        if (l2_addr_valid)
        begin
            if (addr_wait > 0)
            begin
                addr_wait--;
            end
            else
            begin
                l2_addr_ready = 1'b1;
                pending_addr  = l2_addr;
                l2_count++;
                addr_wait     = rand_below(6);
            end
        end
        if (l2_data_ready)
        begin
            if (data_wait > 0)
            begin
                data_wait--;
            end
            else
            begin
                l2_data_valid = 1'b1;
                l2_data       = l2_block(pending_addr);
                data_wait     = rand_below(6);
            end
        end
    endtask

    task automatic tick();
        instr_t exp_word;
        int     due;
        @(posedge CLK);
        #2;
        cycle_count++;
        if (instruction_valid)
        begin
            assert (exp_q.size() > 0)
            else
            begin
                $display("%s: an instruction came back with no fetch outstanding", test_name);
                err_count++;
            end
            if (exp_q.size() > 0)
            begin
                exp_word = exp_q.pop_front();
                due      = due_q.pop_front();
                check_value("instruction", exp_word, instruction);
                if (due >= 0)
                begin
                    check_value("return cycle", due, cycle_count);
                end
            end
        end
        respond_l2();
    endtask

    task automatic fetch_one(input fetch_addr_t addr, input logic timed);
        int waited;
        waited   = 0;
        pc       = addr;
        pc_valid = 1'b1;
        stall    = 1'b0;
        while (!aborted && !cache_ready)
        begin
            tick();
            waited++;
            if (waited >= TIMEOUT)
            begin
                abort_run("cache_ready stayed low while a fetch was waiting");
            end
        end
        if (!aborted)
        begin
            record_accept(addr, timed);
            tick();
        end
        pc_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (!aborted && (exp_q.size() > 0))
        begin
            tick();
            waited++;
            if (waited >= TIMEOUT)
            begin
                abort_run("accepted fetches did not return in time");
            end
        end
    endtask

    task automatic lru_step(input fetch_addr_t addr, input int cost);
        int base;
        base = l2_count;
        fetch_one(addr, 1'b0);
        wait_drain();
        check_value("l2 transfers", base + cost, l2_count);
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial
    begin
        int base;
        int miss_base;
        int accepted;
        int idle_cycles;
        seed          = 32'hd978;
        arst_n        = 1'b0;
        stall         = 1'b0;
        pc            = '0;
        pc_valid      = 1'b0;
        l2_addr_ready = 1'b0;
        l2_data_valid = 1'b0;
        l2_data       = '0;
        cycle_count   = 0;
        err_count     = 0;
        test_count    = 0;
        l2_count      = 0;
        model_misses  = 0;
        aborted       = 1'b0;
        addr_wait     = rand_below(6);
        data_wait     = rand_below(6);
        for (int s = 0; s < 16; s++)
        begin
            model_valid[s][0] = 1'b0;
            model_valid[s][1] = 1'b0;
            model_lru[s]      = 1'b0;
        end
        repeat (4) @(posedge CLK);
        #2;
        arst_n = 1'b1;

        start_test("reset_state");
        check_value("cache_ready", 1, cache_ready);
        check_value("instruction_valid", 0, instruction_valid);
        check_value("l2_addr_valid", 0, l2_addr_valid);
        check_value("l2_data_ready", 0, l2_data_ready);
        end_test();

        start_test("cold_miss");
        base = l2_count;
        fetch_one(32'h0000_1204, 1'b0);
        wait_drain();
        check_value("l2 transfers", base + 1, l2_count);
        check_value("l2 block address", 32'h0000_0120, pending_addr);
        end_test();

        // Whole block back to back, no L2 traffic
        start_test("block_hits");
        base = l2_count;
        for (int i = 0; i < 4; i++)
        begin
            fetch_one(32'h0000_1200 + 4 * i, 1'b1);
        end
        wait_drain();
        check_value("l2 transfers", base, l2_count);
        end_test();

        // Set 5 with blocks A, B, C
        start_test("lru_replace");
        lru_step(32'h0000_a050, 1);
        lru_step(32'h0000_b050, 1);
        lru_step(32'h0000_a058, 0);
        lru_step(32'h0000_c050, 1);
        lru_step(32'h0000_a054, 0);
        lru_step(32'h0000_b05c, 1);
        end_test();

        start_test("random_stream");
        base        = l2_count;
        miss_base   = model_misses;
        accepted    = 0;
        idle_cycles = 0;
        while (!aborted && (accepted < 400))
        begin
            pc = 32'h0002_0000 | (rand_below(3) << 8) | (rand_below(3) << 4)
                 | (rand_below(4) << 2);
            pc_valid = (rand_below(4) != 0);
            stall    = (rand_below(5) == 0);
            if (pc_valid && !stall && cache_ready)
            begin
                record_accept(pc, 1'b0);
                accepted++;
                idle_cycles = 0;
            end
            else
            begin
                idle_cycles++;
                if (idle_cycles >= TIMEOUT)
                begin
                    abort_run("no fetch was accepted for too long");
                end
            end
            tick();
        end
        pc_valid = 1'b0;
        stall    = 1'b0;
        wait_drain();
        check_value("l2 transfers", base + model_misses - miss_base, l2_count);
        end_test();

        $display("Summary: %0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
